//--- hw/bp_pkg.sv
`default_nettype none

package bp_pkg;

  ////////////////////////////////////////
  // Sizes
  ////////////////////////////////////////

  localparam int XLEN           = 32;
  localparam int BP_GLOBAL_BITS = 2;
  localparam int BP_LOCAL_BITS  = 6;
  localparam int BP_LOCAL_LSB   = 2;
  localparam int BP_IDX_BITS    = BP_GLOBAL_BITS + BP_LOCAL_BITS;
  localparam int BP_ENTRIES     = 1 << BP_IDX_BITS;

  ////////////////////////////////////////
  // Types
  ////////////////////////////////////////

  typedef logic [XLEN-1:0]           xlen_t;
  // Top bit is the predicted direction
  typedef logic [1:0]                bp_cnt_t;
  // Newest direction in bit 0
  typedef logic [BP_GLOBAL_BITS-1:0] bp_hist_t;
  typedef logic [BP_IDX_BITS-1:0]    bp_idx_t;
  typedef logic [1:0]                dbg_addr_t;

  // Debug register map
  localparam dbg_addr_t DBG_CTRL     = 2'd0;
  localparam dbg_addr_t DBG_STATUS   = 2'd1;
  localparam dbg_addr_t DBG_BRANCHES = 2'd2;
  localparam dbg_addr_t DBG_MISSES   = 2'd3;

  // Weakly not taken
  localparam bp_cnt_t BP_CNT_RESET = 2'b01;

  // History in the high bits and parcel address bits below
  function automatic bp_idx_t bp_index(input bp_hist_t hist, input xlen_t pc);
    return {hist, pc[BP_LOCAL_LSB +: BP_LOCAL_BITS]};
  endfunction

endpackage

`default_nettype wire

//--- hw/bp_pht.sv
`timescale 1ns/1ps
`default_nettype none

module bp_pht (
  input  wire                  clk_i,
  input  wire                  rst_n_i,

  // Lookup from fetch
  input  wire                  lookup_strb_i,
  input  bp_pkg::xlen_t        lookup_pc_i,
  input  bp_pkg::bp_hist_t     history_i,
  input  wire                  enable_i,
  input  wire                  flush_i,

  // Training write
  input  wire                  wr_strb_i,
  input  bp_pkg::bp_idx_t      wr_idx_i,
  input  bp_pkg::bp_cnt_t      wr_cnt_i,

  output logic                 predict_valid_o,
  output bp_pkg::bp_cnt_t      predict_o,
  output bp_pkg::bp_hist_t     predict_history_o,
  output logic                 busy_o
);

  import bp_pkg::*;

  typedef enum logic {
    clear_idle,
    clear_run
  } clear_state_t;

  clear_state_t clear_state;
  bp_idx_t      sweep_idx;
  bp_idx_t      lookup_idx;
  bp_cnt_t      pht [BP_ENTRIES];

  ////////////////////////////////////////
  // Clear sweep FSM
  ////////////////////////////////////////

  // Starts at reset release and on every flush
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      clear_state <= clear_run;
      sweep_idx   <= '0;
    end
    else if (flush_i)
    begin
      clear_state <= clear_run;
      sweep_idx   <= '0;
    end
    else if (clear_state == clear_run)
    begin
      sweep_idx <= sweep_idx + 1'b1;
      if (sweep_idx == bp_idx_t'(BP_ENTRIES - 1))
      begin
        clear_state <= clear_idle;
      end
    end
  end

  assign busy_o = (clear_state == clear_run);

  ////////////////////////////////////////
  // Counter array
  ////////////////////////////////////////

  // Sweep owns the write port while it runs
  always_ff @(posedge clk_i)
  begin
    if (clear_state == clear_run)
    begin
      pht[sweep_idx] <= BP_CNT_RESET;
    end
    else if (wr_strb_i)
    begin
      pht[wr_idx_i] <= wr_cnt_i;
    end
  end

  ////////////////////////////////////////
  // Registered lookup
  ////////////////////////////////////////

  assign lookup_idx = bp_index(history_i, lookup_pc_i);

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      predict_valid_o <= 1'b0;
    end
    else
    begin
      predict_valid_o <= lookup_strb_i;
    end
  end

  // Old entry value wins over a write in the same cycle
  always_ff @(posedge clk_i)
  begin
    if (lookup_strb_i)
    begin
      predict_history_o <= history_i;
      if (enable_i && (clear_state == clear_idle))
      begin
        predict_o <= pht[lookup_idx];
      end
      else
      begin
        predict_o <= '0;
      end
    end
  end

endmodule

`default_nettype wire

//--- hw/bp_update.sv
`timescale 1ns/1ps
`default_nettype none

module bp_update (
  input  wire                  clk_i,
  input  wire                  rst_n_i,

  // Resolved branch from execute
  input  wire                  update_strb_i,
  input  bp_pkg::xlen_t        update_pc_i,
  input  bp_pkg::bp_hist_t     update_history_i,
  input  bp_pkg::bp_cnt_t      update_predict_i,
  input  wire                  update_taken_i,

  input  wire                  flush_i,

  output bp_pkg::bp_hist_t     history_o,
  output logic                 wr_strb_o,
  output bp_pkg::bp_idx_t      wr_idx_o,
  output bp_pkg::bp_cnt_t      wr_cnt_o,
  output logic                 mispredict_o
);

  import bp_pkg::*;

  bp_cnt_t  cnt_next;
  bp_hist_t history_q;

  ////////////////////////////////////////
  // Counter training
  ////////////////////////////////////////

  // Saturating step on the counter returned with the lookup
  always_comb
  begin
    if (update_taken_i)
    begin
      cnt_next = (update_predict_i == 2'b11) ? 2'b11 : update_predict_i + 2'd1;
    end
    else
    begin
      cnt_next = (update_predict_i == 2'b00) ? 2'b00 : update_predict_i - 2'd1;
    end
  end

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      wr_strb_o <= 1'b0;
    end
    else
    begin
      wr_strb_o <= update_strb_i;
    end
  end

  always_ff @(posedge clk_i)
  begin
    if (update_strb_i)
    begin
      wr_idx_o <= bp_index(update_history_i, update_pc_i);
      wr_cnt_o <= cnt_next;
    end
  end

  // Direction predicted vs resolved
  assign mispredict_o = update_strb_i & (update_predict_i[1] ^ update_taken_i);

  ////////////////////////////////////////
  // Global history
  ////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      history_q <= '0;
    end
    else if (flush_i)
    begin
      history_q <= '0;
    end
    else if (update_strb_i)
    begin
      history_q <= {history_q[BP_GLOBAL_BITS-2:0], update_taken_i};
    end
  end

  assign history_o = history_q;

endmodule

`default_nettype wire

//--- hw/bp_dbg_regs.sv
`timescale 1ns/1ps
`default_nettype none

module bp_dbg_regs (
  input  wire                  clk_i,
  input  wire                  rst_n_i,

  // Debug access
  input  wire                  dbg_strb_i,
  input  wire                  dbg_we_i,
  input  bp_pkg::dbg_addr_t    dbg_addr_i,
  input  bp_pkg::xlen_t        dbg_dati_i,
  output bp_pkg::xlen_t        dbg_dato_o,
  output logic                 dbg_ack_o,

  // Predictor events and status
  input  wire                  update_strb_i,
  input  wire                  mispredict_i,
  input  wire                  busy_i,
  input  bp_pkg::bp_hist_t     history_i,

  output logic                 enable_o,
  output logic                 flush_o
);

  import bp_pkg::*;

  logic  wr_ctrl;
  logic  wr_branches;
  logic  wr_misses;
  xlen_t status;
  xlen_t branches_q;
  xlen_t misses_q;
  xlen_t rd_data;

  ////////////////////////////////////////
  // Write decode
  ////////////////////////////////////////

  assign wr_ctrl     = dbg_strb_i & dbg_we_i & (dbg_addr_i == DBG_CTRL);
  assign wr_branches = dbg_strb_i & dbg_we_i & (dbg_addr_i == DBG_BRANCHES);
  assign wr_misses   = dbg_strb_i & dbg_we_i & (dbg_addr_i == DBG_MISSES);

  // Enable comes out of reset set and flush is a strobe
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      enable_o  <= 1'b1;
      flush_o   <= 1'b0;
      dbg_ack_o <= 1'b0;
    end
    else
    begin
      dbg_ack_o <= dbg_strb_i;
      flush_o   <= wr_ctrl & dbg_dati_i[1];
      if (wr_ctrl)
      begin
        enable_o <= dbg_dati_i[0];
      end
    end
  end

  ////////////////////////////////////////
  // Event counters
  ////////////////////////////////////////

  // Any write clears and wins over a same-cycle event
  always_ff @(posedge clk_i or negedge rst_n_i)
  begin
    if (!rst_n_i)
    begin
      branches_q <= '0;
      misses_q   <= '0;
    end
    else
    begin
      if (wr_branches)
      begin
        branches_q <= '0;
      end
      else if (update_strb_i)
      begin
        branches_q <= branches_q + 1'b1;
      end

      if (wr_misses)
      begin
        misses_q <= '0;
      end
      else if (mispredict_i)
      begin
        misses_q <= misses_q + 1'b1;
      end
    end
  end

  ////////////////////////////////////////
  // Read mux
  ////////////////////////////////////////

  // Busy in bit 0 and history from bit 8
  always_comb
  begin
    status                      = '0;
    status[0]                   = busy_i;
    status[8 +: BP_GLOBAL_BITS] = history_i;
  end

  always_comb
  begin
    case (dbg_addr_i)
      DBG_CTRL:     rd_data = {{(XLEN-1){1'b0}}, enable_o};
      DBG_STATUS:   rd_data = status;
      DBG_BRANCHES: rd_data = branches_q;
      default:      rd_data = misses_q;
    endcase
  end

  // Valid alongside the acknowledge
  always_ff @(posedge clk_i)
  begin
    if (dbg_strb_i)
    begin
      dbg_dato_o <= rd_data;
    end
  end

endmodule

`default_nettype wire

//--- hw/bp_unit.sv
`timescale 1ns/1ps
`default_nettype none

module bp_unit (
  input  wire                  clk_i,
  input  wire                  rst_n_i,

  // Fetch lookup
  input  wire                  lookup_strb_i,
  input  bp_pkg::xlen_t        lookup_pc_i,
  output logic                 predict_valid_o,
  output bp_pkg::bp_cnt_t      predict_o,
  output bp_pkg::bp_hist_t     predict_history_o,

  // Execute update
  input  wire                  update_strb_i,
  input  bp_pkg::xlen_t        update_pc_i,
  input  bp_pkg::bp_hist_t     update_history_i,
  input  bp_pkg::bp_cnt_t      update_predict_i,
  input  wire                  update_taken_i,

  // Debug port
  input  wire                  dbg_strb_i,
  input  wire                  dbg_we_i,
  input  bp_pkg::dbg_addr_t    dbg_addr_i,
  input  bp_pkg::xlen_t        dbg_dati_i,
  output bp_pkg::xlen_t        dbg_dato_o,
  output logic                 dbg_ack_o
);

  import bp_pkg::*;

  bp_hist_t history;
  logic     wr_strb;
  bp_idx_t  wr_idx;
  bp_cnt_t  wr_cnt;
  logic     mispredict;
  logic     enable;
  logic     flush;
  logic     busy;

  bp_pht pht_i (
    .clk_i             (clk_i),
    .rst_n_i           (rst_n_i),
    .lookup_strb_i     (lookup_strb_i),
    .lookup_pc_i       (lookup_pc_i),
    .history_i         (history),
    .enable_i          (enable),
    .flush_i           (flush),
    .wr_strb_i         (wr_strb),
    .wr_idx_i          (wr_idx),
    .wr_cnt_i          (wr_cnt),
    .predict_valid_o   (predict_valid_o),
    .predict_o         (predict_o),
    .predict_history_o (predict_history_o),
    .busy_o            (busy)
  );

  bp_update update_i (
    .clk_i            (clk_i),
    .rst_n_i          (rst_n_i),
    .update_strb_i    (update_strb_i),
    .update_pc_i      (update_pc_i),
    .update_history_i (update_history_i),
    .update_predict_i (update_predict_i),
    .update_taken_i   (update_taken_i),
    .flush_i          (flush),
    .history_o        (history),
    .wr_strb_o        (wr_strb),
    .wr_idx_o         (wr_idx),
    .wr_cnt_o         (wr_cnt),
    .mispredict_o     (mispredict)
  );

  // Register block steering the predictor
  bp_dbg_regs dbg_regs_i (
    .clk_i         (clk_i),
    .rst_n_i       (rst_n_i),
    .dbg_strb_i    (dbg_strb_i),
    .dbg_we_i      (dbg_we_i),
    .dbg_addr_i    (dbg_addr_i),
    .dbg_dati_i    (dbg_dati_i),
    .dbg_dato_o    (dbg_dato_o),
    .dbg_ack_o     (dbg_ack_o),
    .update_strb_i (update_strb_i),
    .mispredict_i  (mispredict),
    .busy_i        (busy),
    .history_i     (history),
    .enable_o      (enable),
    .flush_o       (flush)
  );

endmodule

`default_nettype wire

//--- tb/bp_tb.sv
`timescale 1ns/1ps
`default_nettype none

module bp_tb;

  import bp_pkg::*;

  // Several times the length of all tests and their sweeps
  localparam int CYCLE_LIMIT = 20000;

  logic      clk;
  logic      rst_n;
  logic      lookup_strb;
  xlen_t     lookup_pc;
  logic      predict_valid;
  bp_cnt_t   predict;
  bp_hist_t  predict_history;
  logic      update_strb;
  xlen_t     update_pc;
  bp_hist_t  update_history;
  bp_cnt_t   update_predict;
  logic      update_taken;
  logic      dbg_strb;
  logic      dbg_we;
  dbg_addr_t dbg_addr;
  xlen_t     dbg_dati;
  xlen_t     dbg_dato;
  logic      dbg_ack;

  // Reference model
  bp_cnt_t   ref_pht [BP_ENTRIES];
  bp_hist_t  ref_hist;
  xlen_t     ref_branches;
  xlen_t     ref_misses;
  logic      ref_enable;

  logic [31:0] lfsr_state;
  int          errors;
  int          checks;
  int          cycles;

  bp_unit bp_unit_i (
    .clk_i             (clk),
    .rst_n_i           (rst_n),
    .lookup_strb_i     (lookup_strb),
    .lookup_pc_i       (lookup_pc),
    .predict_valid_o   (predict_valid),
    .predict_o         (predict),
    .predict_history_o (predict_history),
    .update_strb_i     (update_strb),
    .update_pc_i       (update_pc),
    .update_history_i  (update_history),
    .update_predict_i  (update_predict),
    .update_taken_i    (update_taken),
    .dbg_strb_i        (dbg_strb),
    .dbg_we_i          (dbg_we),
    .dbg_addr_i        (dbg_addr),
    .dbg_dati_i        (dbg_dati),
    .dbg_dato_o        (dbg_dato),
    .dbg_ack_o         (dbg_ack)
  );

  initial
  begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  always @(posedge clk)
  begin
    cycles <= cycles + 1;
    if (cycles >= CYCLE_LIMIT)
    begin
      $display("timeout: the tests did not finish within %0d cycles", CYCLE_LIMIT);
      $display("sim failed");
      $finish;
    end
  end

  ////////////////////////////////////////
  // Model helpers
  ////////////////////////////////////////

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA3000000) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  function automatic xlen_t rand_bits(input int n);
    xlen_t v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_state = lfsr_next(lfsr_state);
      v = {v[XLEN-2:0], lfsr_state[0]};
    end
    return v;
  endfunction

  // History above and parcel address bits below
  function automatic int model_index(input bp_hist_t hist, input xlen_t pc);
    int low;
    low = int'((pc >> BP_LOCAL_LSB) % (1 << BP_LOCAL_BITS));
    return int'(hist) * (1 << BP_LOCAL_BITS) + low;
  endfunction

  function automatic bp_cnt_t train(input bp_cnt_t c, input logic taken);
    int v;
    v = int'(c) + (taken ? 1 : -1);
    if (v > 3)
    begin
      v = 3;
    end
    if (v < 0)
    begin
      v = 0;
    end
    return bp_cnt_t'(v);
  endfunction

  ////////////////////////////////////////
  // Compare tasks
  ////////////////////////////////////////

  task automatic check_cnt(input bp_cnt_t got, input bp_cnt_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_hist(input bp_hist_t got, input bp_hist_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %0t: %s got %b expected %b", $time, what, got, exp);
    end
  endtask

  task automatic check_word(input xlen_t got, input xlen_t exp, input string what);
    checks++;
    if (got !== exp)
    begin
      errors++;
      $display("error %0t: %s got %h expected %h", $time, what, got, exp);
    end
  endtask

  ////////////////////////////////////////
  // Bus drivers
  ////////////////////////////////////////

  task automatic step();
    @(posedge clk);
    #2;
  endtask

  task automatic dbg_read(input dbg_addr_t addr, output xlen_t data);
    dbg_strb = 1'b1;
    dbg_we   = 1'b0;
    dbg_addr = addr;
    step();
    dbg_strb = 1'b0;
    check_word(xlen_t'(dbg_ack), 32'd1, "dbg_ack_o on read");
    data = dbg_dato;
  endtask

  task automatic dbg_write(input dbg_addr_t addr, input xlen_t data);
    dbg_strb = 1'b1;
    dbg_we   = 1'b1;
    dbg_addr = addr;
    dbg_dati = data;
    step();
    dbg_strb = 1'b0;
    dbg_we   = 1'b0;
    check_word(xlen_t'(dbg_ack), 32'd1, "dbg_ack_o on write");
  endtask

  // Poll status until the sweep ends
  task automatic wait_idle();
    xlen_t s;
    dbg_read(DBG_STATUS, s);
    while (s[0])
    begin
      dbg_read(DBG_STATUS, s);
    end
    check_hist(bp_hist_t'(s >> 8), ref_hist, "status history");
  endtask

  // Hands back the counter and history that the DUT returned
  task automatic do_lookup(input xlen_t pc, output bp_cnt_t cnt, output bp_hist_t hist);
    bp_cnt_t exp_cnt;
    exp_cnt     = ref_enable ? ref_pht[model_index(ref_hist, pc)] : 2'b00;
    lookup_strb = 1'b1;
    lookup_pc   = pc;
    step();
    lookup_strb = 1'b0;
    check_word(xlen_t'(predict_valid), 32'd1, "predict_valid_o after strobe");
    check_cnt(predict, exp_cnt, "predict_o");
    check_hist(predict_history, ref_hist, "predict_history_o");
    cnt  = predict;
    hist = predict_history;
    step();
    check_word(xlen_t'(predict_valid), 32'd0, "predict_valid_o one cycle only");
  endtask

  // Second step lets the registered table write land
  task automatic send_update(input xlen_t pc, input bp_hist_t hist, input bp_cnt_t pred,
                             input logic taken);
    update_strb    = 1'b1;
    update_pc      = pc;
    update_history = hist;
    update_predict = pred;
    update_taken   = taken;
    step();
    update_strb = 1'b0;
    ref_pht[model_index(hist, pc)] = train(pred, taken);
    ref_branches = ref_branches + 32'd1;
    if (pred[1] !== taken)
    begin
      ref_misses = ref_misses + 32'd1;
    end
    ref_hist = bp_hist_t'({ref_hist, taken});
    step();
  endtask

  task automatic branch(input xlen_t pc, input logic taken);
    bp_cnt_t  c;
    bp_hist_t h;
    do_lookup(pc, c, h);
    send_update(pc, h, c, taken);
  endtask

  ////////////////////////////////////////
  // Directed tests
  ////////////////////////////////////////

  task automatic test_reset_state();
    bp_cnt_t  c;
    bp_hist_t h;
    wait_idle();
    repeat (8)
    begin
      do_lookup(rand_bits(32), c, h);
    end
  endtask

  task automatic test_training();
    xlen_t    pc;
    bp_cnt_t  c;
    bp_hist_t h;
    pc = rand_bits(32);
    // Same returned history so one entry trains
    repeat (4)
    begin
      send_update(pc, 2'b11, ref_pht[model_index(2'b11, pc)], 1'b1);
    end
    do_lookup(pc, c, h);
    check_cnt(c, 2'b11, "saturated taken entry");
    repeat (4)
    begin
      send_update(pc, 2'b11, ref_pht[model_index(2'b11, pc)], 1'b0);
    end
    // Steer history back to 11 through a neighbour address
    repeat (2)
    begin
      send_update(pc ^ 32'h4, ref_hist, ref_pht[model_index(ref_hist, pc ^ 32'h4)], 1'b1);
    end
    do_lookup(pc, c, h);
    check_cnt(c, 2'b00, "saturated not taken entry");
  endtask

  task automatic test_history();
    xlen_t pool [4];
    xlen_t s;
    for (int i = 0; i < 4; i++)
    begin
      pool[i] = rand_bits(32);
    end
    repeat (16)
    begin
      branch(pool[rand_bits(2)], rand_bits(1) != 0);
      dbg_read(DBG_STATUS, s);
      check_hist(bp_hist_t'(s >> 8), ref_hist, "status history");
      check_word(s & 32'h1, 32'd0, "status busy");
    end
  endtask

  task automatic test_counters();
    xlen_t w;
    dbg_read(DBG_BRANCHES, w);
    check_word(w, ref_branches, "branch count");
    dbg_read(DBG_MISSES, w);
    check_word(w, ref_misses, "miss count");
    dbg_write(DBG_BRANCHES, 32'h0);
    ref_branches = '0;
    dbg_read(DBG_BRANCHES, w);
    check_word(w, 32'd0, "branch count after clear");
    dbg_read(DBG_MISSES, w);
    check_word(w, ref_misses, "miss count kept");
    dbg_write(DBG_MISSES, 32'hffff_ffff);
    ref_misses = '0;
    repeat (6)
    begin
      branch(rand_bits(32), rand_bits(1) != 0);
    end
    dbg_read(DBG_BRANCHES, w);
    check_word(w, ref_branches, "branch count");
    dbg_read(DBG_MISSES, w);
    check_word(w, ref_misses, "miss count");
  endtask

  task automatic test_enable();
    xlen_t    pool [4];
    xlen_t    w;
    bp_cnt_t  c;
    bp_hist_t h;
    for (int i = 0; i < 4; i++)
    begin
      pool[i] = rand_bits(32);
    end
    dbg_write(DBG_CTRL, 32'h0);
    ref_enable = 1'b0;
    dbg_read(DBG_CTRL, w);
    check_word(w, 32'd0, "ctrl disabled");
    repeat (8)
    begin
      branch(pool[rand_bits(2)], rand_bits(1) != 0);
    end
    dbg_write(DBG_CTRL, 32'h1);
    ref_enable = 1'b1;
    dbg_read(DBG_CTRL, w);
    check_word(w, 32'd1, "ctrl enabled");
    for (int i = 0; i < 4; i++)
    begin
      do_lookup(pool[i], c, h);
    end
  endtask

  task automatic test_flush();
    xlen_t    w;
    bp_cnt_t  c;
    bp_hist_t h;
    dbg_write(DBG_CTRL, 32'h3);
    step();
    dbg_read(DBG_STATUS, w);
    check_word(w & 32'h1, 32'd1, "status busy after flush");
    for (int i = 0; i < BP_ENTRIES; i++)
    begin
      ref_pht[i] = BP_CNT_RESET;
    end
    ref_hist = '0;
    check_hist(bp_hist_t'(w >> 8), ref_hist, "status history after flush");
    wait_idle();
    dbg_read(DBG_CTRL, w);
    check_word(w, 32'd1, "ctrl after flush");
    // Visit histories 00, 01, 11, 10 and read every entry
    for (int k = 0; k < 4; k++)
    begin
      for (int a = 0; a < (1 << BP_LOCAL_BITS); a++)
      begin
        do_lookup(xlen_t'(a) << BP_LOCAL_LSB, c, h);
      end
      if (k < 3)
      begin
        send_update(32'h0, ref_hist, ref_pht[model_index(ref_hist, 32'h0)], k < 2);
      end
    end
  endtask

  ////////////////////////////////////////
  // Main sequence
  ////////////////////////////////////////

  initial
  begin
    rst_n          = 1'b0;
    lookup_strb    = 1'b0;
    lookup_pc      = '0;
    update_strb    = 1'b0;
    update_pc      = '0;
    update_history = '0;
    update_predict = '0;
    update_taken   = 1'b0;
    dbg_strb       = 1'b0;
    dbg_we         = 1'b0;
    dbg_addr       = '0;
    dbg_dati       = '0;
    lfsr_state     = 32'h82be1603;
    errors         = 0;
    checks         = 0;
    cycles         = 0;
    for (int i = 0; i < BP_ENTRIES; i++)
    begin
      ref_pht[i] = BP_CNT_RESET;
    end
    ref_hist     = '0;
    ref_branches = '0;
    ref_misses   = '0;
    ref_enable   = 1'b1;

    repeat (5) @(posedge clk);
    #2;
    rst_n = 1'b1;

    test_reset_state();
    test_training();
    test_history();
    test_counters();
    test_enable();
    test_flush();

    $display("checks: %0d, errors: %0d", checks, errors);
    if (errors == 0)
    begin
      $display("sim passed");
    end
    else
    begin
      $display("sim failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hw/bp_pkg.sv
hw/bp_pht.sv
hw/bp_update.sv
hw/bp_dbg_regs.sv
hw/bp_unit.sv
tb/bp_tb.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build with Verilator, run, then look for the fail message in the log
cd "$(dirname "$0")" || exit 1

verilator --binary --timing -Wno-fatal --top-module bp_tb -f compile.f \
  -o bp_tb_sim > build.log 2>&1 \
  && ./obj_dir/bp_tb_sim > sim.log 2>&1 \
  || { cat build.log sim.log 2>/dev/null; echo "build or run error"; exit 1; }

cat sim.log
grep -q "sim failed" sim.log && exit 1 || exit 0
